/* common/fft_pkg.sv */
`default_nettype none

package fft_pkg;

	// transform size
	localparam int FFT_POINTS = 16;
	localparam int FFT_STAGES = 4;

	// fraction bits of the twiddle factors
	localparam int FRACTION = 8;

	typedef logic signed [7:0]  sample_t;
	typedef logic signed [15:0] word_t;
	typedef logic signed [9:0]  twiddle_t;
	typedef logic        [3:0]  bin_idx_t;

	// one complex point, real part in the upper half
	typedef struct packed {
		word_t re;
		word_t im;
	} cplx_t;

	// core sequencing, IDLE is also where samples are collected
	typedef enum logic [1:0] {
		FFT_IDLE,
		FFT_LOAD,
		FFT_COMPUTE,
		FFT_DONE
	} fft_state_t;

endpackage

`default_nettype wire

/* common/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	typedef logic [7:0] uart_byte_t;

	// receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	// transmitter FSM
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage

`default_nettype wire

/* uart/uart_rx.sv */
`default_nettype none

module uart_rx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  wire                  i_clk,
	input  wire                  w_FFT_cycle_done,
	input  wire                  i_rx_bit,
	output uart_pkg::uart_byte_t o_byte,
	output logic                 o_byte_valid,
	output logic                 o_rx_error
);
	import uart_pkg::*;

	localparam int CNT_W    = $clog2(CLKS_PER_BIT);
	localparam int HALF_BIT = CLKS_PER_BIT / 2;

	logic             rx_meta;
	logic             rx_sync;
	logic             rx_prev;
	rx_state_t        state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	uart_byte_t       shift;
	logic             start_edge;
	logic             bit_end;
	logic             half_end;

	assign o_byte     = shift;
	assign start_edge = rx_prev & ~rx_sync;
	assign bit_end    = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
	assign half_end   = (clk_cnt == CNT_W'(HALF_BIT - 1));

	// data bits enter from the top, LSB first on the line
	always_ff @(posedge i_clk) begin
		if (state == RX_DATA && bit_end)
			shift <= {rx_sync, shift[7:1]};
	end

	always_ff @(posedge i_clk or posedge w_FFT_cycle_done) begin
		if (w_FFT_cycle_done) begin
			rx_meta      <= 1'b1;
			rx_sync      <= 1'b1;
			rx_prev      <= 1'b1;
			state        <= RX_IDLE;
			clk_cnt      <= '0;
			bit_idx      <= '0;
			o_byte_valid <= 1'b0;
			o_rx_error   <= 1'b0;
		end else begin
			// two-flop synchroniser plus one flop for edge detection
			rx_meta      <= i_rx_bit;
			rx_sync      <= rx_meta;
			rx_prev      <= rx_sync;
			o_byte_valid <= 1'b0;
			o_rx_error   <= 1'b0;
			clk_cnt      <= bit_end ? '0 : clk_cnt + 1'b1;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (start_edge)
						state <= RX_START;
				end
				RX_START: begin
					// re-check the line at the middle of the start bit
					if (half_end) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? RX_IDLE : RX_DATA;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (bit_end) begin
						state        <= RX_IDLE;
						o_byte_valid <= rx_sync;
						o_rx_error   <= ~rx_sync;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`default_nettype none

module uart_tx #(
	parameter int CLKS_PER_BIT = 8
) (
	input  wire                       i_clk,
	input  wire                       w_FFT_cycle_done,
	input  wire                       i_start,
	input  wire uart_pkg::uart_byte_t i_tx_byte,
	output logic                      o_tx_bit,
	output logic                      o_tx_done
);
	import uart_pkg::*;

	localparam int CNT_W = $clog2(CLKS_PER_BIT);

	tx_state_t        state;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	uart_byte_t       shift;
	logic             bit_end;

	assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge i_clk) begin
		if (state == TX_IDLE && i_start)
			shift <= i_tx_byte;
		else if (state == TX_DATA && bit_end)
			shift <= shift >> 1;
	end

	always_ff @(posedge i_clk or posedge w_FFT_cycle_done) begin
		if (w_FFT_cycle_done) begin
			state     <= TX_IDLE;
			clk_cnt   <= '0;
			bit_idx   <= '0;
			o_tx_bit  <= 1'b1;
			o_tx_done <= 1'b0;
		end else begin
			o_tx_done <= 1'b0;
			clk_cnt   <= bit_end ? '0 : clk_cnt + 1'b1;
			case (state)
				TX_IDLE: begin
					clk_cnt  <= '0;
					o_tx_bit <= 1'b1;
					if (i_start) begin
						state    <= TX_START;
						o_tx_bit <= 1'b0;
					end
				end
				TX_START: begin
					if (bit_end) begin
						state    <= TX_DATA;
						bit_idx  <= '0;
						o_tx_bit <= shift[0];
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state    <= TX_STOP;
							o_tx_bit <= 1'b1;
						end else begin
							// shift[0] is still the bit just sent
							o_tx_bit <= shift[1];
						end
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						state     <= TX_IDLE;
						o_tx_done <= 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* fft/fft_twiddle_rom.sv */
`default_nettype none

module fft_twiddle_rom (
	input  wire [2:0]        i_k,
	output fft_pkg::twiddle_t o_w_re,
	output fft_pkg::twiddle_t o_w_im
);

	// W16^k = cos(2*pi*k/16) - j*sin(2*pi*k/16), scaled by 256
	always_comb begin
		case (i_k)
			3'd0: {o_w_re, o_w_im} = {10'sd256, 10'sd0};
			3'd1: {o_w_re, o_w_im} = {10'sd237, -10'sd98};
			3'd2: {o_w_re, o_w_im} = {10'sd181, -10'sd181};
			3'd3: {o_w_re, o_w_im} = {10'sd98, -10'sd237};
			3'd4: {o_w_re, o_w_im} = {10'sd0, -10'sd256};
			3'd5: {o_w_re, o_w_im} = {-10'sd98, -10'sd237};
			3'd6: {o_w_re, o_w_im} = {-10'sd181, -10'sd181};
			default: {o_w_re, o_w_im} = {-10'sd237, -10'sd98};
		endcase
	end

endmodule

`default_nettype wire

/* fft/fft_butterfly.sv */
`default_nettype none

module fft_butterfly (
	input  wire fft_pkg::cplx_t    i_a,
	input  wire fft_pkg::cplx_t    i_b,
	input  wire fft_pkg::twiddle_t i_w_re,
	input  wire fft_pkg::twiddle_t i_w_im,
	output fft_pkg::cplx_t         o_top,
	output fft_pkg::cplx_t         o_bot
);
	import fft_pkg::*;

	// word times twiddle, plus one bit for the sum of two products
	localparam int PROD_W = $bits(word_t) + $bits(twiddle_t) + 1;

	logic signed [PROD_W-1:0] prod_re_full;
	logic signed [PROD_W-1:0] prod_im_full;
	word_t                    prod_re;
	word_t                    prod_im;

	always_comb begin
		// complex b * w at full precision
		prod_re_full = i_b.re * i_w_re - i_b.im * i_w_im;
		prod_im_full = i_b.re * i_w_im + i_b.im * i_w_re;

		// back to Q0, truncating toward minus infinity
		prod_re = word_t'(prod_re_full >>> FRACTION);
		prod_im = word_t'(prod_im_full >>> FRACTION);

		// sums wrap at 16 bits, no saturation
		o_top.re = i_a.re + prod_re;
		o_top.im = i_a.im + prod_im;
		o_bot.re = i_a.re - prod_re;
		o_bot.im = i_a.im - prod_im;
	end

endmodule

`default_nettype wire

/* fft/fft_core.sv */
`default_nettype none

module fft_core (
	input  wire                                           i_clk,
	input  wire                                           w_FFT_cycle_done,
	input  wire fft_pkg::sample_t                         i_sample,
	input  wire                                           i_sample_valid,
	output fft_pkg::cplx_t [fft_pkg::FFT_POINTS-1:0]      o_result,
	output logic                                          o_fft_done
);
	import fft_pkg::*;

	localparam int BFLY_PER_STAGE = FFT_POINTS / 2;
	localparam int STAGE_W        = $clog2(FFT_STAGES);
	localparam int BFLY_W         = $clog2(BFLY_PER_STAGE);

	fft_state_t              state;
	bin_idx_t                sample_cnt;
	logic [STAGE_W-1:0]      stage;
	logic [BFLY_W-1:0]       bfly;
	cplx_t [FFT_POINTS-1:0]  buffer;

	bin_idx_t                load_addr;
	logic                    load_en;
	bin_idx_t                idx_mask;
	bin_idx_t                idx_top;
	bin_idx_t                idx_bot;
	logic [BFLY_W-1:0]       tw_k;
	twiddle_t                w_re;
	twiddle_t                w_im;
	cplx_t                   bf_top;
	cplx_t                   bf_bot;

	// results are read in place from the working buffer
	assign o_result = buffer;

	// samples land in bit-reversed order so the output comes out natural
	assign load_addr = {sample_cnt[0], sample_cnt[1], sample_cnt[2], sample_cnt[3]};
	assign load_en   = (state == FFT_IDLE) && i_sample_valid;

	// butterfly addressing for the current stage
	// span is 2^stage, twiddle step is N / 2^(stage+1)
	always_comb begin
		idx_mask = bin_idx_t'((5'd1 << stage) - 5'd1);
		idx_top  = ((bin_idx_t'(bfly) & ~idx_mask) << 1) | (bin_idx_t'(bfly) & idx_mask);
		idx_bot  = idx_top | bin_idx_t'(5'd1 << stage);
		tw_k     = (bfly & idx_mask[BFLY_W-1:0]) << (STAGE_W'(FFT_STAGES - 1) - stage);
	end

	fft_twiddle_rom u_twiddle (
		.i_k    (tw_k),
		.o_w_re (w_re),
		.o_w_im (w_im)
	);

	fft_butterfly u_butterfly (
		.i_a    (buffer[idx_top]),
		.i_b    (buffer[idx_bot]),
		.i_w_re (w_re),
		.i_w_im (w_im),
		.o_top  (bf_top),
		.o_bot  (bf_bot)
	);

	always_ff @(posedge i_clk) begin
		if (load_en) begin
			buffer[load_addr] <= '{re: word_t'(i_sample), im: '0};
		end else if (state == FFT_COMPUTE) begin
			buffer[idx_top] <= bf_top;
			buffer[idx_bot] <= bf_bot;
		end
	end

	always_ff @(posedge i_clk or posedge w_FFT_cycle_done) begin
		if (w_FFT_cycle_done) begin
			state      <= FFT_IDLE;
			sample_cnt <= '0;
			stage      <= '0;
			bfly       <= '0;
			o_fft_done <= 1'b0;
		end else begin
			o_fft_done <= 1'b0;
			case (state)
				FFT_IDLE: begin
					if (i_sample_valid) begin
						sample_cnt <= sample_cnt + 1'b1;
						if (sample_cnt == bin_idx_t'(FFT_POINTS - 1))
							state <= FFT_LOAD;
					end
				end
				FFT_LOAD: begin
					// last sample is now in the buffer
					stage <= '0;
					bfly  <= '0;
					state <= FFT_COMPUTE;
				end
				FFT_COMPUTE: begin
					bfly <= bfly + 1'b1;
					if (bfly == BFLY_W'(BFLY_PER_STAGE - 1)) begin
						stage <= stage + 1'b1;
						if (stage == STAGE_W'(FFT_STAGES - 1))
							state <= FFT_DONE;
					end
				end
				FFT_DONE: begin
					o_fft_done <= 1'b1;
					state      <= FFT_IDLE;
				end
				default: state <= FFT_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/result_serializer.sv */
`default_nettype none

module result_serializer (
	input  wire                                      i_clk,
	input  wire                                      w_FFT_cycle_done,
	input  wire fft_pkg::cplx_t [fft_pkg::FFT_POINTS-1:0] i_result,
	input  wire                                      i_fft_done,
	input  wire                                      i_tx_done,
	output uart_pkg::uart_byte_t                     o_tx_byte,
	output logic                                     o_tx_start,
	output logic                                     o_busy
);
	import fft_pkg::*;

	localparam int BYTES = 2 * FFT_POINTS;
	localparam int CNT_W = $clog2(BYTES);

	logic [CNT_W-1:0] byte_cnt;
	bin_idx_t         bin;
	word_t            bin_re;

	// even count sends the low byte, odd count the high byte
	assign bin       = byte_cnt[CNT_W-1:1];
	assign bin_re    = i_result[bin].re;
	assign o_tx_byte = byte_cnt[0] ? bin_re[15:8] : bin_re[7:0];

	always_ff @(posedge i_clk or posedge w_FFT_cycle_done) begin
		if (w_FFT_cycle_done) begin
			byte_cnt   <= '0;
			o_tx_start <= 1'b0;
			o_busy     <= 1'b0;
		end else begin
			o_tx_start <= 1'b0;
			if (!o_busy) begin
				if (i_fft_done) begin
					byte_cnt   <= '0;
					o_busy     <= 1'b1;
					o_tx_start <= 1'b1;
				end
			end else if (i_tx_done) begin
				if (byte_cnt == CNT_W'(BYTES - 1)) begin
					o_busy <= 1'b0;
				end else begin
					byte_cnt   <= byte_cnt + 1'b1;
					o_tx_start <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/ofdm_fft_top.sv */
`default_nettype none

module ofdm_fft_top #(
	parameter int CLKS_PER_BIT = 8
) (
	input  wire i_clk,
	input  wire w_FFT_cycle_done,
	input  wire i_rx_bit,
	output wire o_tx_bit
);
	import uart_pkg::*;
	import fft_pkg::*;

	uart_byte_t             rx_byte;
	logic                   rx_valid;
	logic                   sample_valid;
	cplx_t [FFT_POINTS-1:0] result;
	logic                   fft_done;
	uart_byte_t             tx_byte;
	logic                   tx_start;
	logic                   tx_done;
	logic                   busy;

	// drop input while a result is out on the line
	// fft_done covers the cycle before busy rises
	assign sample_valid = rx_valid & ~(busy | fft_done);

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
		.i_clk            (i_clk),
		.w_FFT_cycle_done (w_FFT_cycle_done),
		.i_rx_bit         (i_rx_bit),
		.o_byte           (rx_byte),
		.o_byte_valid     (rx_valid),
		.o_rx_error       ()
	);

	fft_core u_fft (
		.i_clk            (i_clk),
		.w_FFT_cycle_done (w_FFT_cycle_done),
		.i_sample         (sample_t'(rx_byte)),
		.i_sample_valid   (sample_valid),
		.o_result         (result),
		.o_fft_done       (fft_done)
	);

	result_serializer u_ser (
		.i_clk            (i_clk),
		.w_FFT_cycle_done (w_FFT_cycle_done),
		.i_result         (result),
		.i_fft_done       (fft_done),
		.i_tx_done        (tx_done),
		.o_tx_byte        (tx_byte),
		.o_tx_start       (tx_start),
		.o_busy           (busy)
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
		.i_clk            (i_clk),
		.w_FFT_cycle_done (w_FFT_cycle_done),
		.i_start          (tx_start),
		.i_tx_byte        (tx_byte),
		.o_tx_bit         (o_tx_bit),
		.o_tx_done        (tx_done)
	);

endmodule

`default_nettype wire

/* bench/fft_ref_model.svh */
`ifndef FFT_REF_MODEL_SVH
`define FFT_REF_MODEL_SVH

// integer 16-point FFT, decimation in time with bit-reversed input
// model_in holds the samples, model_re gets the real part of each bin
int model_in [16];
int model_re [16];

// low 16 bits read back as a signed value
function automatic int wrap16(input int value);
	logic signed [15:0] low;
	low = value[15:0];
	return int'(low);
endfunction

// scale to Q8 and round to nearest, halves away from zero
function automatic int round_q8(input real value);
	real scaled;
	scaled = value * 256.0;
	if (scaled >= 0.0)
		return $rtoi(scaled + 0.5);
	else
		return -$rtoi(0.5 - scaled);
endfunction

function automatic int bit_reverse4(input int idx);
	return ((idx & 1) << 3) | ((idx & 2) << 1) | ((idx & 4) >> 1) | ((idx & 8) >> 3);
endfunction

task automatic compute_reference();
	int re [16];
	int im [16];
	int n;
	int s;
	int g;
	int j;
	int span;
	int top;
	int bot;
	int w_re;
	int w_im;
	int prod_re;
	int prod_im;
	for (n = 0; n < 16; n++) begin
		re[bit_reverse4(n)] = model_in[n];
		im[bit_reverse4(n)] = 0;
	end
	for (s = 0; s < 4; s++) begin
		span = 1 << s;
		for (g = 0; g < 16; g += 2 * span) begin
			for (j = 0; j < span; j++) begin
				top  = g + j;
				bot  = top + span;
				// W16^k with k = j * 16 / (2 * span)
				w_re = round_q8($cos(2.0 * 3.14159265358979 * (j * 8 / span) / 16.0));
				w_im = round_q8(-$sin(2.0 * 3.14159265358979 * (j * 8 / span) / 16.0));
				prod_re = wrap16((re[bot] * w_re - im[bot] * w_im) >>> 8);
				prod_im = wrap16((re[bot] * w_im + im[bot] * w_re) >>> 8);
				re[bot] = wrap16(re[top] - prod_re);
				im[bot] = wrap16(im[top] - prod_im);
				re[top] = wrap16(re[top] + prod_re);
				im[top] = wrap16(im[top] + prod_im);
			end
		end
	end
	for (n = 0; n < 16; n++)
		model_re[n] = re[n];
endtask

`endif

/* bench/tb_ofdm_fft.sv */
`default_nettype none

module tb_ofdm_fft;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLKS_PER_BIT = 8;
	// eight frames in all since the drop test sends two
	localparam int NUM_FRAMES   = 8;
	localparam int WATCHDOG_NS  = NUM_FRAMES * (16 + 32) * 10 * CLKS_PER_BIT * 8 * 2;

	logic       clk;
	logic       rst;
	logic       rx_bit;
	wire        tx_bit;
	int         errors;
	int         checks;
	integer     seed;
	logic [7:0] frame_bytes [16];
	logic [7:0] rx_bytes [32];
	int         exp_re [16];

	`include "fft_ref_model.svh"

	ofdm_fft_top #(.CLKS_PER_BIT(CLKS_PER_BIT)) uut (
		.i_clk            (clk),
		.w_FFT_cycle_done (rst),
		.i_rx_bit         (rx_bit),
		.o_tx_bit         (tx_bit)
	);

	always #4 clk = ~clk;

	// one 8N1 byte plus one idle bit driven on the falling edge
	task automatic uart_send(input logic [7:0] data, input logic stop_bit);
		int b;
		@(negedge clk);
		rx_bit = 1'b0;
		repeat (CLKS_PER_BIT) @(negedge clk);
		for (b = 0; b < 8; b++) begin
			rx_bit = data[b];
			repeat (CLKS_PER_BIT) @(negedge clk);
		end
		rx_bit = stop_bit;
		repeat (CLKS_PER_BIT) @(negedge clk);
		rx_bit = 1'b1;
		repeat (CLKS_PER_BIT) @(negedge clk);
	endtask

	task automatic uart_recv(input int index, output logic [7:0] data);
		int b;
		@(negedge tx_bit);
		// middle of the start bit
		repeat (CLKS_PER_BIT / 2) @(negedge clk);
		for (b = 0; b < 8; b++) begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			data[b] = tx_bit;
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		checks++;
		assert (tx_bit === 1'b1) else begin
			errors++;
			$display("Fail at %0t: o_tx_bit stop bit of byte %0d expected 1 got %b",
				$time, index, tx_bit);
		end
	endtask

	task automatic send_frame();
		int n;
		for (n = 0; n < 16; n++)
			uart_send(frame_bytes[n], 1'b1);
	endtask

	task automatic receive_frame();
		int i;
		logic [7:0] data;
		for (i = 0; i < 32; i++) begin
			uart_recv(i, data);
			rx_bytes[i] = data;
		end
	endtask

	// bytes come low byte first from bin 0 up to bin 15
	task automatic compare_frame();
		int i;
		int word;
		logic [7:0] exp_byte;
		for (i = 0; i < 32; i++) begin
			word     = exp_re[i / 2];
			exp_byte = (i % 2) ? word[15:8] : word[7:0];
			checks++;
			assert (rx_bytes[i] === exp_byte) else begin
				errors++;
				$display("Fail at %0t: bin%0d %s byte expected %02h got %02h", $time, i / 2,
					(i % 2) ? "high" : "low", exp_byte, rx_bytes[i]);
			end
		end
	endtask

	task automatic random_frame_with_model();
		int n;
		integer rnd;
		for (n = 0; n < 16; n++) begin
			rnd            = $random(seed);
			frame_bytes[n] = rnd[7:0];
			model_in[n]    = $signed(frame_bytes[n]);
		end
		compute_reference();
		for (n = 0; n < 16; n++)
			exp_re[n] = model_re[n];
	endtask

	task automatic run_frame();
		send_frame();
		receive_frame();
		compare_frame();
	endtask

	task automatic test_idle_line();
		repeat (200) begin
			@(negedge clk);
			checks++;
			assert (tx_bit === 1'b1) else begin
				errors++;
				$display("Fail at %0t: o_tx_bit expected 1 got %b", $time, tx_bit);
			end
		end
	endtask

	task automatic test_impulse();
		int n;
		for (n = 0; n < 16; n++) begin
			frame_bytes[n] = (n == 0) ? 8'd100 : 8'd0;
			exp_re[n]      = 100;
		end
		run_frame();
	endtask

	// sum of sixteen -3 lands in bin 0 only
	task automatic test_constant();
		int n;
		for (n = 0; n < 16; n++) begin
			frame_bytes[n] = 8'hfd;
			exp_re[n]      = (n == 0) ? -48 : 0;
		end
		run_frame();
	endtask

	task automatic test_random_frames();
		repeat (3) begin
			random_frame_with_model();
			run_frame();
		end
	endtask

	task automatic test_drop_during_tx();
		random_frame_with_model();
		send_frame();
		fork
			receive_frame();
			begin
				@(negedge tx_bit);
				uart_send(8'h5a, 1'b1);
			end
		join
		compare_frame();
		random_frame_with_model();
		run_frame();
	endtask

	task automatic test_bad_stop_bit();
		uart_send(8'hc3, 1'b0);
		random_frame_with_model();
		run_frame();
	endtask

	initial begin
		$timeformat(-9, 0, " ns", 0);
		clk    = 1'b0;
		rst    = 1'b1;
		rx_bit = 1'b1;
		errors = 0;
		checks = 0;
		seed   = 84471;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		test_idle_line();
		test_impulse();
		test_constant();
		test_random_frames();
		test_drop_during_tx();
		test_bad_stop_bit();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the DUT stopped sending", WATCHDOG_NS);
		$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+bench
common/fft_pkg.sv
common/uart_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
fft/fft_twiddle_rom.sv
fft/fft_butterfly.sv
fft/fft_core.sv
hdl/result_serializer.sv
hdl/ofdm_fft_top.sv
bench/tb_ofdm_fft.sv
